//--- cpuCore.f
rtl/cpuIsaPkg.sv
rtl/cpuCtrlPkg.sv
rtl/datapathCtrlIf.sv
rtl/registerFile.sv
rtl/executeUnit.sv
rtl/cpuControl.sv
rtl/cpuDatapath.sv
rtl/cpuCore.sv
test/cpuCoreTb.sv

//--- runSim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module cpuCoreTb -f cpuCore.f -o simCpuCore &&
./obj_dir/simCpuCore || exit 1

//--- test/cpuCoreTb.sv
module cpuCoreTb;
	import cpuIsaPkg::*;

	localparam int memWords = 512;
	localparam int bodyLen = 40;
	localparam int idleLimit = 64;
	localparam opcodeT branchOps [4] = '{opBeq, opBne, opBle, opBgt};

	logic Clock = 1'b0;
	logic rstN;
	logic memValid;
	logic memWrite;
	dataWord memAddr;
	dataWord memWdata;
	logic memReady;
	dataWord memRdata;

	integer seed;
	dataWord mem [memWords];
	dataWord modelMem [memWords];
	dataWord modelRegs [32];
	dataWord haltPc;
	dataWord expAddr [$];
	logic expWrite [$];
	dataWord expData [$];
	logic heldValid;
	logic heldWrite;
	dataWord heldAddr;
	dataWord heldData;

	cpuCore uut
	(
		.Clock(Clock),
		.rstN(rstN),
		.memValid(memValid),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memReady(memReady),
		.memRdata(memRdata)
	);

	always #5 Clock = ~Clock;

	function automatic int pickBelow(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic checkAddress(input string name, input dataWord expected, input dataWord actual);
		if (actual !== expected)
			abortRun($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic checkData(input string name, input dataWord expected, input dataWord actual);
		if (actual !== expected)
			abortRun($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic checkWrite(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abortRun($sformatf("ERROR %s: expected %b, actual %b", name, expected, actual));
	endtask

	task automatic setReg(input regIndex idx, input dataWord value);
		if (idx != 5'd0)
			modelRegs[idx] = value;
	endtask

	task automatic expectRequest(input dataWord addr, input logic write, input dataWord data);
		expAddr.push_back(addr);
		expWrite.push_back(write);
		expData.push_back(data);
	endtask

	task automatic buildProgram();
		int kind;
		int skip;
		regIndex rs;
		regIndex rt;
		regIndex rd;
		logic [4:0] shamt;
		logic [15:0] imm;
		for (int a = 0; a < memWords; a++)
			mem[a] = $random(seed);
		for (int i = 0; i < bodyLen; i++)
		begin
			rs = regIndex'(pickBelow(8));
			rt = regIndex'(pickBelow(8));
			rd = regIndex'(pickBelow(8));
			shamt = 5'(pickBelow(32));
			imm = 16'(pickBelow(65536));
			skip = 1 + pickBelow(3);
			kind = pickBelow(16);
			if ((kind == 13 || kind == 14) && i + 1 + skip > bodyLen)
				kind = 7; // no room for a forward skip
			case (kind)
				0: mem[i] = {opRType, rs, rt, rd, 5'd0, fnAdd};
				1: mem[i] = {opRType, rs, rt, rd, 5'd0, fnSub};
				2: mem[i] = {opRType, rs, rt, rd, 5'd0, fnAnd};
				3: mem[i] = {opRType, rs, rt, rd, 5'd0, fnSlt};
				4: mem[i] = {opRType, 5'd0, rt, rd, shamt, fnSll};
				5: mem[i] = {opRType, 5'd0, rt, rd, shamt, fnSrl};
				6: mem[i] = {opRType, 5'd0, rt, rd, shamt, fnSra};
				7: mem[i] = {opAddi, rs, rt, imm};
				8: mem[i] = {opAddiu, rs, rt, imm};
				9: mem[i] = {opSlti, rs, rt, imm};
				10: mem[i] = {opLui, 5'd0, rt, imm};
				11: mem[i] = {opLw, 5'd0, rt, 16'(16'h400 + 4 * pickBelow(64))};
				12: mem[i] = {opSw, 5'd0, rt, 16'(16'h400 + 4 * pickBelow(64))};
				13: mem[i] = {branchOps[pickBelow(4)], rs, (pickBelow(4) == 0) ? rs : rt, 16'(skip)};
				14: mem[i] = {opJ, 26'(i + 1 + skip)};
				default: mem[i] = (pickBelow(2) == 0) ? {6'h3f, rs, rt, imm}
					: {opRType, rs, rt, rd, shamt, 6'h3e}; // undefined opcode or funct
			endcase
		end
		for (int r = 1; r < 8; r++)
			mem[bodyLen + r - 1] = {opSw, 5'd0, 5'(r), 16'(16'h500 + 4 * r)};
		haltPc = dataWord'((bodyLen + 7) * 4);
		mem[bodyLen + 7] = {opJ, 26'(bodyLen + 7)}; // jump to itself
	endtask

	task automatic runModel();
		dataWord pc;
		dataWord npc;
		dataWord word;
		dataWord sImm;
		dataWord addr;
		dataWord a;
		dataWord b;
		regIndex rt;
		regIndex rd;
		int haltFetches;
		modelMem = mem;
		for (int r = 0; r < 32; r++)
			modelRegs[r] = '0;
		pc = '0;
		haltFetches = 0;
		while (haltFetches < 2)
		begin
			word = modelMem[pc[10:2]];
			expectRequest(pc, 1'b0, '0);
			if (pc == haltPc)
				haltFetches++;
			npc = pc + 32'd4;
			rt = word[20:16];
			rd = word[15:11];
			sImm = {{16{word[15]}}, word[15:0]};
			a = modelRegs[word[25:21]];
			b = modelRegs[rt];
			case (word[31:26])
				opRType:
					case (word[5:0])
						fnAdd: setReg(rd, a + b);
						fnSub: setReg(rd, a - b);
						fnAnd: setReg(rd, a & b);
						fnSlt: setReg(rd, {31'd0, $signed(a) < $signed(b)});
						fnSll: setReg(rd, b << word[10:6]);
						fnSrl: setReg(rd, b >> word[10:6]);
						fnSra: setReg(rd, $signed(b) >>> word[10:6]);
						default: ;
					endcase
				opAddi, opAddiu: setReg(rt, a + sImm);
				opSlti: setReg(rt, {31'd0, $signed(a) < $signed(sImm)});
				opLui: setReg(rt, {word[15:0], 16'd0});
				opLw:
				begin
					addr = a + sImm;
					expectRequest(addr, 1'b0, '0);
					setReg(rt, modelMem[addr[10:2]]);
				end
				opSw:
				begin
					addr = a + sImm;
					expectRequest(addr, 1'b1, b);
					modelMem[addr[10:2]] = b;
				end
				opBeq: if (a == b) npc = npc + (sImm << 2);
				opBne: if (a != b) npc = npc + (sImm << 2);
				opBle: if ($signed(a) <= $signed(b)) npc = npc + (sImm << 2);
				opBgt: if ($signed(a) > $signed(b)) npc = npc + (sImm << 2);
				opJ: npc = {npc[31:28], word[25:0], 2'b00};
				default: ;
			endcase
			pc = npc;
		end
	endtask

	// a stalled request must come back unchanged
	task automatic checkHeld();
		if (heldValid)
		begin
			if (!memValid)
				abortRun("memory request was withdrawn before it was accepted");
			checkAddress("held address", heldAddr, memAddr);
			checkWrite("held write flag", heldWrite, memWrite);
			if (heldWrite)
				checkData("held store data", heldData, memWdata);
		end
	endtask

	initial
	begin
		int idle;
		logic accepted;
		dataWord wantAddr;
		logic wantWrite;
		dataWord wantData;
		seed = 32'h8fcb3780;
		rstN = 1'b0;
		memReady = 1'b0;
		memRdata = '0;
		heldValid = 1'b0;
		buildProgram();
		runModel();
		repeat (2) @(posedge Clock);
		#1;
		rstN = 1'b1;
		@(negedge Clock);
		if (memValid !== 1'b0)
			abortRun("memValid was high in the first cycle after reset");
		while (expAddr.size() > 0)
		begin
			idle = 0;
			accepted = 1'b0;
			while (!accepted)
			begin
				@(posedge Clock);
				#1;
				memReady = ($random(seed) & 3) != 0; // ready about three cycles in four
				memRdata = mem[memAddr[10:2]];
				@(negedge Clock);
				checkHeld();
				accepted = memValid && memReady;
				heldValid = memValid && !memReady;
				heldWrite = memWrite;
				heldAddr = memAddr;
				heldData = memWdata;
				idle++;
				if (!accepted && idle > idleLimit)
					abortRun("timed out waiting for a memory request to be accepted");
			end
			wantAddr = expAddr.pop_front();
			wantWrite = expWrite.pop_front();
			wantData = expData.pop_front();
			checkAddress("request address", wantAddr, memAddr);
			checkWrite("request write flag", wantWrite, memWrite);
			if (wantWrite)
			begin
				checkData("store data", wantData, memWdata);
				mem[memAddr[10:2]] = memWdata;
			end
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- rtl/cpuCore.sv
module cpuCore
(
	input logic Clock,
	input logic rstN,
	output logic memValid,
	output logic memWrite,
	output cpuIsaPkg::dataWord memAddr,
	output cpuIsaPkg::dataWord memWdata,
	input logic memReady,
	input cpuIsaPkg::dataWord memRdata
);

	datapathCtrlIf ctlBus();

	cpuControl control
	(
		.Clock(Clock),
		.rstN(rstN),
		.memValid(memValid),
		.memWrite(memWrite),
		.memReady(memReady),
		.ctl(ctlBus.ctrl)
	);

	cpuDatapath datapath
	(
		.Clock(Clock),
		.rstN(rstN),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memRdata(memRdata),
		.dp(ctlBus.path)
	);

endmodule

//--- rtl/cpuDatapath.sv
module cpuDatapath
(
	input logic Clock,
	input logic rstN,
	output cpuIsaPkg::dataWord memAddr,
	output cpuIsaPkg::dataWord memWdata,
	input cpuIsaPkg::dataWord memRdata,
	datapathCtrlIf.path dp
);
	import cpuIsaPkg::*;
	import cpuCtrlPkg::*;

	dataWord pc;
	instruction ir;
	dataWord regA;
	dataWord regB;
	dataWord result;
	dataWord loadData;
	dataWord rfA;
	dataWord rfB;
	dataWord aluB;
	dataWord aluOut;
	dataWord signImm;
	dataWord zeroImm;
	dataWord nextPc;
	dataWord writeData;
	regIndex writeIdx;

	assign signImm = {{16{ir.i.imm[15]}}, ir.i.imm};
	assign zeroImm = {16'b0, ir.i.imm};
	assign writeIdx = (dp.dest == destRd) ? ir.r.rd : ir.r.rt;
	assign writeData = (dp.wbSrc == wbLoad) ? loadData : result;
	assign memAddr = dp.addrFromResult ? result : pc;
	assign memWdata = regB;
	assign dp.instr = ir;

	always_comb
	begin
		case (dp.srcB)
			srcSignImm: aluB = signImm;
			srcZeroImm: aluB = zeroImm;
			default: aluB = regB;
		endcase
	end

	always_comb
	begin
		case (dp.pcSel)
			pcBranch: nextPc = pc + {signImm[29:0], 2'b00}; // pc already past the branch
			pcJump: nextPc = {pc[31:28], ir.i.rs, ir.i.rt, ir.i.imm, 2'b00};
			default: nextPc = pc + instrStep;
		endcase
	end

	always_ff @(posedge Clock)
	begin
		if (!rstN)
			pc <= '0;
		else if (dp.pcLoad)
			pc <= nextPc;
	end

	always_ff @(posedge Clock)
	begin
		if (dp.irLoad)
			ir <= memRdata;
		if (dp.resultLoad)
			result <= aluOut;
		regA <= rfA;
		regB <= rfB;
		loadData <= memRdata; // only the accepting cycle's word is used
	end

	registerFile regs
	(
		.Clock(Clock),
		.rstN(rstN),
		.readA(ir.r.rs),
		.readB(ir.r.rt),
		.dataA(rfA),
		.dataB(rfB),
		.writeEn(dp.regWrite),
		.writeIdx(writeIdx),
		.writeData(writeData)
	);

	executeUnit alu
	(
		.op(dp.opSel),
		.a(regA),
		.b(aluB),
		.shamt(ir.r.shamt),
		.result(aluOut),
		.eq(dp.eq),
		.lt(dp.lt),
		.gt(dp.gt)
	);

endmodule

//--- rtl/cpuControl.sv
module cpuControl
(
	input logic Clock,
	input logic rstN,
	output logic memValid,
	output logic memWrite,
	input logic memReady,
	datapathCtrlIf.ctrl ctl
);
	import cpuIsaPkg::*;
	import cpuCtrlPkg::*;

	ctrlState state;
	ctrlState nextState;
	opcodeT opcode;
	functT funct;
	logic isRType;
	logic knownR;
	logic taken;
	aluOp instrOp;

	assign opcode = ctl.instr.r.opcode;
	assign funct = ctl.instr.r.funct;
	assign isRType = opcode == opRType;
	assign knownR = funct inside {fnAdd, fnSub, fnAnd, fnSlt, fnSll, fnSrl, fnSra};

	always_ff @(posedge Clock)
	begin
		if (!rstN)
			state <= sReset;
		else
			state <= nextState;
	end

	always_comb
	begin
		instrOp = aluAdd; // addi, addiu and address calc
		if (isRType)
		begin
			case (funct)
				fnSub: instrOp = aluSub;
				fnAnd: instrOp = aluAnd;
				fnSlt: instrOp = aluSlt;
				fnSll: instrOp = aluSll;
				fnSrl: instrOp = aluSrl;
				fnSra: instrOp = aluSra;
				default: instrOp = aluAdd;
			endcase
		end
		else if (opcode == opSlti)
			instrOp = aluSlt;
		else if (opcode == opLui)
			instrOp = aluLui;
	end

	always_comb
	begin
		case (opcode)
			opBeq: taken = ctl.eq;
			opBne: taken = !ctl.eq;
			opBle: taken = ctl.lt || ctl.eq;
			default: taken = ctl.gt; // bgt
		endcase
	end

	always_comb
	begin
		nextState = state;
		memValid = 1'b0;
		memWrite = 1'b0;
		ctl.irLoad = 1'b0;
		ctl.pcLoad = 1'b0;
		ctl.pcSel = pcInc;
		ctl.opSel = aluAdd;
		ctl.srcB = srcReg;
		ctl.dest = destRt;
		ctl.wbSrc = wbAlu;
		ctl.regWrite = 1'b0;
		ctl.resultLoad = 1'b0;
		ctl.addrFromResult = 1'b0;
		case (state)
			sReset: nextState = sFetch;
			sFetch:
			begin
				memValid = 1'b1;
				ctl.irLoad = memReady;
				ctl.pcLoad = memReady;
				if (memReady)
					nextState = sDecode;
			end
			sDecode:
			begin
				if (isRType)
					nextState = knownR ? sExecute : sFetch;
				else
				begin
					case (opcode)
						opAddi, opAddiu, opSlti, opLui: nextState = sExecute;
						opLw, opSw: nextState = sMemAddr;
						opBeq, opBne, opBle, opBgt: nextState = sBranch;
						opJ: nextState = sJump;
						default: nextState = sFetch; // unknown opcode is a no-op
					endcase
				end
			end
			sExecute:
			begin
				ctl.opSel = instrOp;
				if (!isRType)
					ctl.srcB = (opcode == opLui) ? srcZeroImm : srcSignImm;
				ctl.resultLoad = 1'b1;
				nextState = sAluWrite;
			end
			sAluWrite:
			begin
				ctl.regWrite = 1'b1;
				ctl.dest = isRType ? destRd : destRt;
				nextState = sFetch;
			end
			sMemAddr:
			begin
				ctl.srcB = srcSignImm;
				ctl.resultLoad = 1'b1;
				nextState = (opcode == opLw) ? sMemRead : sMemWrite;
			end
			sMemRead:
			begin
				memValid = 1'b1;
				ctl.addrFromResult = 1'b1;
				if (memReady)
					nextState = sLoadWrite;
			end
			sLoadWrite:
			begin
				ctl.regWrite = 1'b1;
				ctl.wbSrc = wbLoad;
				nextState = sFetch;
			end
			sMemWrite:
			begin
				memValid = 1'b1;
				memWrite = 1'b1;
				ctl.addrFromResult = 1'b1;
				if (memReady)
					nextState = sFetch;
			end
			sBranch:
			begin
				ctl.pcSel = pcBranch; // flags compare rs against rt
				ctl.pcLoad = taken;
				nextState = sFetch;
			end
			sJump:
			begin
				ctl.pcSel = pcJump;
				ctl.pcLoad = 1'b1;
				nextState = sFetch;
			end
			default: nextState = sFetch;
		endcase
	end

endmodule

//--- rtl/executeUnit.sv
module executeUnit
(
	input cpuCtrlPkg::aluOp op,
	input cpuIsaPkg::dataWord a,
	input cpuIsaPkg::dataWord b,
	input logic [4:0] shamt,
	output cpuIsaPkg::dataWord result,
	output logic eq,
	output logic lt,
	output logic gt
);
	import cpuCtrlPkg::*;

	// signed compare, shared by slt and the branches
	assign eq = a == b;
	assign lt = $signed(a) < $signed(b);
	assign gt = !eq && !lt;

	always_comb
	begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluSlt: result = {31'b0, lt};
			aluSll: result = b << shamt;
			aluSrl: result = b >> shamt;
			aluSra: result = $signed(b) >>> shamt;
			aluLui: result = {b[15:0], 16'b0};
			default: result = a + b;
		endcase
	end

endmodule

//--- rtl/registerFile.sv
module registerFile
(
	input logic Clock,
	input logic rstN,
	input cpuIsaPkg::regIndex readA,
	input cpuIsaPkg::regIndex readB,
	output cpuIsaPkg::dataWord dataA,
	output cpuIsaPkg::dataWord dataB,
	input logic writeEn,
	input cpuIsaPkg::regIndex writeIdx,
	input cpuIsaPkg::dataWord writeData
);
	import cpuIsaPkg::*;

	dataWord regs [32];

	assign dataA = regs[readA];
	assign dataB = regs[readB];

	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (writeEn && writeIdx != '0) // r0 stays zero
			regs[writeIdx] <= writeData;
	end

endmodule

//--- rtl/datapathCtrlIf.sv
interface datapathCtrlIf;
	import cpuIsaPkg::*;
	import cpuCtrlPkg::*;

	logic irLoad;
	logic pcLoad;
	pcSrcSel pcSel;
	aluOp opSel;
	srcBSel srcB;
	destSel dest;
	wbSel wbSrc;
	logic regWrite;
	logic resultLoad;
	logic addrFromResult;

	instruction instr;
	logic eq;
	logic lt;
	logic gt;

	modport ctrl (output irLoad, pcLoad, pcSel, opSel, srcB, dest, wbSrc, regWrite,
		resultLoad, addrFromResult, input instr, eq, lt, gt);
	modport path (input irLoad, pcLoad, pcSel, opSel, srcB, dest, wbSrc, regWrite,
		resultLoad, addrFromResult, output instr, eq, lt, gt);

endinterface

//--- rtl/cpuCtrlPkg.sv
package cpuCtrlPkg;

	typedef enum logic [3:0] {
		sReset,
		sFetch,
		sDecode,
		sExecute,
		sAluWrite,
		sMemAddr,
		sMemRead,
		sLoadWrite,
		sMemWrite,
		sBranch,
		sJump
	} ctrlState;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluSlt,
		aluSll,
		aluSrl,
		aluSra,
		aluLui
	} aluOp;

	typedef enum logic [1:0] {
		srcReg,
		srcSignImm,
		srcZeroImm
	} srcBSel;

	typedef enum logic {destRd, destRt} destSel;

	typedef enum logic {wbAlu, wbLoad} wbSel;

	// next pc source
	typedef enum logic [1:0] {pcInc, pcBranch, pcJump} pcSrcSel;

endpackage

//--- rtl/cpuIsaPkg.sv
package cpuIsaPkg;

	typedef logic [31:0] dataWord;
	typedef logic [4:0] regIndex;
	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;

	localparam opcodeT opRType = 6'h00;
	localparam opcodeT opJ = 6'h02;
	localparam opcodeT opBeq = 6'h04;
	localparam opcodeT opBne = 6'h05;
	localparam opcodeT opBle = 6'h06;
	localparam opcodeT opBgt = 6'h07;
	localparam opcodeT opAddi = 6'h08;
	localparam opcodeT opAddiu = 6'h09;
	localparam opcodeT opSlti = 6'h0a;
	localparam opcodeT opLui = 6'h0f;
	localparam opcodeT opLw = 6'h23;
	localparam opcodeT opSw = 6'h2b;

	localparam functT fnSll = 6'h00;
	localparam functT fnSrl = 6'h02;
	localparam functT fnSra = 6'h03;
	localparam functT fnAdd = 6'h20;
	localparam functT fnSub = 6'h22;
	localparam functT fnAnd = 6'h24;
	localparam functT fnSlt = 6'h2a;

	localparam dataWord instrStep = 32'd4;

	typedef struct packed {
		opcodeT opcode;
		regIndex rs;
		regIndex rt;
		regIndex rd;
		logic [4:0] shamt;
		functT funct;
	} rFields;

	typedef struct packed {
		opcodeT opcode;
		regIndex rs;
		regIndex rt;
		logic [15:0] imm; // low 26 bits double as jump target
	} iFields;

	typedef union packed {
		rFields r;
		iFields i;
	} instruction;

endpackage
